// ==== hw/socBusPkg.sv ====
// Bus widths, GPIO register map and arbiter states shared by all RTL modules through a wildcard import
`default_nettype none

package socBusPkg;

    // Data path matches the 16 board LEDs and switches
    localparam int BUS_DATA_W = 16;

    // Room for 16 registers, four are mapped
    localparam int REG_ADDR_W = 4;

    // One register bus data word
    typedef logic [BUS_DATA_W-1:0] busData_t;

    // One register address
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // GPIO register map
    localparam regAddr_t ADDR_LED     = 4'd0;
    localparam regAddr_t ADDR_SW      = 4'd1;
    localparam regAddr_t ADDR_CTRL    = 4'd2;
    localparam regAddr_t ADDR_SCRATCH = 4'd3;

    // CTRL bit that turns the mirror engine on
    localparam int CTRL_MIRROR_BIT = 0;

    // Arbiter FSM
    // IDLE grants, the WAIT states hold the bus until the register block answers
    typedef enum logic [1:0] {
        IDLE,
        WAIT_HOST,
        WAIT_MIRROR
    } arbState_t;

endpackage

`default_nettype wire

// ==== hw/gpioRegs.sv ====
// GPIO register block answering single-cycle register bus accesses, the bus target in boardTop
`timescale 1ns/1ps
`default_nettype none

module gpioRegs
    import socBusPkg::*;
(
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     busValid,
    input  wire logic     busWrite,
    input  wire regAddr_t busAddr,
    input  wire busData_t busWData,
    output logic          busRValid,
    output busData_t      busRData,
    input  wire busData_t sw,
    output busData_t      led,
    output logic          mirrorEnable
);

    busData_t swMeta;
    busData_t swSync;
    busData_t ledReg;
    busData_t scratchReg;
    logic     ctrlEnable;
    busData_t readMux;
    logic     wrStrobe;

    assign wrStrobe = busValid && busWrite;

    // Two-flop synchronizer for the asynchronous switch pins
    always_ff @(posedge clk) begin
        swMeta <= sw;
        swSync <= swMeta;
    end

    // LED and CTRL, SW and unmapped writes dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ledReg     <= '0;
            ctrlEnable <= 1'b0;
        end else if (wrStrobe) begin
            case (busAddr)
                ADDR_LED:  ledReg <= busWData;
                ADDR_CTRL: ctrlEnable <= busWData[CTRL_MIRROR_BIT];
                default:   ;
            endcase
        end
    end

    // Scratch word
    always_ff @(posedge clk) begin
        if (wrStrobe && busAddr == ADDR_SCRATCH) begin
            scratchReg <= busWData;
        end
    end

    // Read decode, unmapped reads as zero
    always_comb begin
        readMux = '0;
        case (busAddr)
            ADDR_LED:     readMux = ledReg;
            ADDR_SW:      readMux = swSync;
            ADDR_CTRL:    readMux[CTRL_MIRROR_BIT] = ctrlEnable;
            ADDR_SCRATCH: readMux = scratchReg;
            default:      readMux = '0;
        endcase
    end

    // Every access answered one cycle later, writes included
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busRValid <= 1'b0;
        end else begin
            busRValid <= busValid;
        end
    end

    always_ff @(posedge clk) begin
        if (busValid) begin
            busRData <= readMux;
        end
    end

    assign led          = ledReg;
    assign mirrorEnable = ctrlEnable;

endmodule

`default_nettype wire

// ==== hw/busArbiter.sv ====
// Round-robin arbiter joining the host port and the mirror engine onto the single register bus
`timescale 1ns/1ps
`default_nettype none

module busArbiter
    import socBusPkg::*;
(
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     hostReq,
    input  wire logic     hostReqWrite,
    input  wire regAddr_t hostReqAddr,
    input  wire busData_t hostReqData,
    output logic          hostGnt,
    output logic          hostRespValid,
    output busData_t      hostRespData,
    input  wire logic     mirrorReq,
    input  wire logic     mirrorReqWrite,
    input  wire regAddr_t mirrorReqAddr,
    input  wire busData_t mirrorReqData,
    output logic          mirrorGnt,
    output logic          mirrorRespValid,
    output busData_t      mirrorRespData,
    output logic          busValid,
    output logic          busWrite,
    output regAddr_t      busAddr,
    output busData_t      busWData,
    input  wire logic     busRValid,
    input  wire busData_t busRData
);

    arbState_t state;
    logic      mirrorFirst;  // Round-robin pointer

    // Grant only from IDLE, so one transaction at a time
    always_comb begin
        hostGnt   = 1'b0;
        mirrorGnt = 1'b0;
        if (state == IDLE) begin
            if (hostReq && (!mirrorReq || !mirrorFirst)) begin
                hostGnt = 1'b1;
            end else if (mirrorReq) begin
                mirrorGnt = 1'b1;
            end
        end
    end

    // Winner drives the bus in its grant cycle
    assign busValid = hostGnt || mirrorGnt;
    assign busWrite = mirrorGnt ? mirrorReqWrite : hostReqWrite;
    assign busAddr  = mirrorGnt ? mirrorReqAddr  : hostReqAddr;
    assign busWData = mirrorGnt ? mirrorReqData  : hostReqData;

    // Priority goes to the other requester after every grant
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= IDLE;
            mirrorFirst <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (hostGnt) begin
                        state       <= WAIT_HOST;
                        mirrorFirst <= 1'b1;
                    end else if (mirrorGnt) begin
                        state       <= WAIT_MIRROR;
                        mirrorFirst <= 1'b0;
                    end
                end
                WAIT_HOST, WAIT_MIRROR: if (busRValid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Response only to the requester that owns the bus
    assign hostRespValid   = busRValid && (state == WAIT_HOST);
    assign hostRespData    = (state == WAIT_HOST) ? busRData : '0;
    assign mirrorRespValid = busRValid && (state == WAIT_MIRROR);
    assign mirrorRespData  = (state == WAIT_MIRROR) ? busRData : '0;

    assert property (@(posedge clk) disable iff (!arstN) !(hostGnt && mirrorGnt))
        else $error("busArbiter: both requesters granted");

    // Register block must answer in the next cycle or the FSM stalls
    assert property (@(posedge clk) disable iff (!arstN) busValid |=> busRValid)
        else $error("busArbiter: no register response one cycle after grant");

endmodule

`default_nettype wire

// ==== hw/switchMirror.sv ====
// Periodic engine that copies the switch register into the LED register over the shared bus
`timescale 1ns/1ps
`default_nettype none

module switchMirror
    import socBusPkg::*;
#(
    parameter int MIRROR_PERIOD = 16
) (
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     mirrorEnable,
    output logic          req,
    output logic          reqWrite,
    output regAddr_t      reqAddr,
    output busData_t      reqData,
    input  wire logic     gnt,
    input  wire logic     respValid,
    input  wire busData_t respData
);

    localparam int CNT_W = (MIRROR_PERIOD > 1) ? $clog2(MIRROR_PERIOD) : 1;

    // One pass is a read of SW then a write to LED
    typedef enum logic [2:0] {
        PASS_IDLE,
        PASS_RD_REQ,
        PASS_RD_WAIT,
        PASS_WR_REQ,
        PASS_WR_WAIT
    } passState_t;

    passState_t       state;
    logic [CNT_W-1:0] periodCnt;
    logic             periodDone;
    busData_t         swValue;

    assign periodDone = (periodCnt == CNT_W'(MIRROR_PERIOD - 1));

    // Free-running while enabled, parked at zero otherwise
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else if (!mirrorEnable || periodDone) begin
            periodCnt <= '0;
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    // A pass started is always finished, even if disabled midway
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= PASS_IDLE;
        end else begin
            case (state)
                PASS_IDLE:    if (mirrorEnable && periodDone) state <= PASS_RD_REQ;
                PASS_RD_REQ:  if (gnt) state <= PASS_RD_WAIT;
                PASS_RD_WAIT: if (respValid) state <= PASS_WR_REQ;
                PASS_WR_REQ:  if (gnt) state <= PASS_WR_WAIT;
                PASS_WR_WAIT: if (respValid) state <= PASS_IDLE;
                default:      state <= PASS_IDLE;
            endcase
        end
    end

    // Switch value from the read, written back next
    always_ff @(posedge clk) begin
        if (state == PASS_RD_WAIT && respValid) begin
            swValue <= respData;
        end
    end

    assign req      = (state == PASS_RD_REQ) || (state == PASS_WR_REQ);
    assign reqWrite = (state == PASS_WR_REQ);
    assign reqAddr  = reqWrite ? ADDR_LED : ADDR_SW;
    assign reqData  = swValue;

    // Request held until the arbiter takes it
    assert property (@(posedge clk) disable iff (!arstN) req && !gnt |=> req)
        else $error("switchMirror: request withdrawn before grant");

endmodule

`default_nettype wire

// ==== hw/hostCmdPort.sv ====
// Host command FIFO with credit return, one of the two bus requesters inside boardTop
`timescale 1ns/1ps
`default_nettype none

module hostCmdPort
    import socBusPkg::*;
#(
    parameter int CMD_DEPTH = 4
) (
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire logic     cmdValid,
    input  wire logic     cmdWrite,
    input  wire regAddr_t cmdAddr,
    input  wire busData_t cmdData,
    output logic          cmdCredit,
    output logic          rspValid,
    output busData_t      rspData,
    output logic          req,
    output logic          reqWrite,
    output regAddr_t      reqAddr,
    output busData_t      reqData,
    input  wire logic     gnt,
    input  wire logic     respValid,
    input  wire busData_t respData
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    // Entry storage, one slot per host credit
    logic     fifoWrite [CMD_DEPTH];
    regAddr_t fifoAddr  [CMD_DEPTH];
    busData_t fifoData  [CMD_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             fifoEmpty;
    logic             fifoFull;
    logic             busy;         // Request granted, response not yet back
    logic             pendingRead;
    logic             push;
    logic             pop;

    // Wrap at the last slot, depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CMD_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Host pushes freely, credits keep it from overflowing
    assign push      = cmdValid;
    assign pop       = gnt;
    assign fifoEmpty = (count == '0);
    assign fifoFull  = (count == CNT_W'(CMD_DEPTH));

    // Head entry is the bus request
    assign req      = !fifoEmpty && !busy;
    assign reqWrite = fifoWrite[rdPtr];
    assign reqAddr  = fifoAddr[rdPtr];
    assign reqData  = fifoData[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifoWrite[wrPtr] <= cmdWrite;
            fifoAddr[wrPtr]  <= cmdAddr;
            fifoData[wrPtr]  <= cmdData;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // One request in flight, remember whether it wants data back
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy        <= 1'b0;
            pendingRead <= 1'b0;
        end else if (gnt) begin
            busy        <= 1'b1;
            pendingRead <= !fifoWrite[rdPtr];
        end else if (respValid) begin
            busy        <= 1'b0;
            pendingRead <= 1'b0;
        end
    end

    // Credit back on grant, read data back on response
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmdCredit <= 1'b0;
            rspValid  <= 1'b0;
        end else begin
            cmdCredit <= gnt;
            rspValid  <= respValid && pendingRead;
        end
    end

    always_ff @(posedge clk) begin
        if (respValid) begin
            rspData <= respData;
        end
    end

    // Host broke the credit contract
    assert property (@(posedge clk) disable iff (!arstN) cmdValid |-> !fifoFull)
        else $error("hostCmdPort: command pushed into a full FIFO");

endmodule

`default_nettype wire

// ==== hw/boardTop.sv ====
// Board-level wrapper joining the host port and mirror engine to the GPIO registers, the simulation top
`timescale 1ns/1ps
`default_nettype none

module boardTop
    import socBusPkg::*;
#(
    parameter int CMD_DEPTH     = 4,
    parameter int MIRROR_PERIOD = 16
) (
    input  wire logic     clk,
    input  wire logic     arstN,
    input  wire busData_t sw,
    output busData_t      led,
    input  wire logic     cmdValid,
    input  wire logic     cmdWrite,
    input  wire regAddr_t cmdAddr,
    input  wire busData_t cmdData,
    output logic          cmdCredit,
    output logic          rspValid,
    output busData_t      rspData
);

    // Reset release synchronizer
    logic [1:0] rstSync;
    logic       sysArstN;

    // Host requester
    logic       hostReq;
    logic       hostReqWrite;
    regAddr_t   hostReqAddr;
    busData_t   hostReqData;
    logic       hostGnt;
    logic       hostRespValid;
    busData_t   hostRespData;

    // Mirror requester
    logic       mirrorReq;
    logic       mirrorReqWrite;
    regAddr_t   mirrorReqAddr;
    busData_t   mirrorReqData;
    logic       mirrorGnt;
    logic       mirrorRespValid;
    busData_t   mirrorRespData;

    // Shared register bus
    logic       busValid;
    logic       busWrite;
    regAddr_t   busAddr;
    busData_t   busWData;
    logic       busRValid;
    busData_t   busRData;
    logic       mirrorEnable;

    // Assert at once, release two clocks after the pin goes high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rstSync <= 2'b00;
        end else begin
            rstSync <= {rstSync[0], 1'b1};
        end
    end

    assign sysArstN = rstSync[1];

    // External command path
    hostCmdPort #(
        .CMD_DEPTH(CMD_DEPTH)
    ) uHostCmdPort (
        .clk       (clk),
        .arstN     (sysArstN),
        .cmdValid  (cmdValid),
        .cmdWrite  (cmdWrite),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdCredit (cmdCredit),
        .rspValid  (rspValid),
        .rspData   (rspData),
        .req       (hostReq),
        .reqWrite  (hostReqWrite),
        .reqAddr   (hostReqAddr),
        .reqData   (hostReqData),
        .gnt       (hostGnt),
        .respValid (hostRespValid),
        .respData  (hostRespData)
    );

    // Switch to LED copy engine
    switchMirror #(
        .MIRROR_PERIOD(MIRROR_PERIOD)
    ) uSwitchMirror (
        .clk          (clk),
        .arstN        (sysArstN),
        .mirrorEnable (mirrorEnable),
        .req          (mirrorReq),
        .reqWrite     (mirrorReqWrite),
        .reqAddr      (mirrorReqAddr),
        .reqData      (mirrorReqData),
        .gnt          (mirrorGnt),
        .respValid    (mirrorRespValid),
        .respData     (mirrorRespData)
    );

    busArbiter uBusArbiter (
        .clk             (clk),
        .arstN           (sysArstN),
        .hostReq         (hostReq),
        .hostReqWrite    (hostReqWrite),
        .hostReqAddr     (hostReqAddr),
        .hostReqData     (hostReqData),
        .hostGnt         (hostGnt),
        .hostRespValid   (hostRespValid),
        .hostRespData    (hostRespData),
        .mirrorReq       (mirrorReq),
        .mirrorReqWrite  (mirrorReqWrite),
        .mirrorReqAddr   (mirrorReqAddr),
        .mirrorReqData   (mirrorReqData),
        .mirrorGnt       (mirrorGnt),
        .mirrorRespValid (mirrorRespValid),
        .mirrorRespData  (mirrorRespData),
        .busValid        (busValid),
        .busWrite        (busWrite),
        .busAddr         (busAddr),
        .busWData        (busWData),
        .busRValid       (busRValid),
        .busRData        (busRData)
    );

    gpioRegs uGpioRegs (
        .clk          (clk),
        .arstN        (sysArstN),
        .busValid     (busValid),
        .busWrite     (busWrite),
        .busAddr      (busAddr),
        .busWData     (busWData),
        .busRValid    (busRValid),
        .busRData     (busRData),
        .sw           (sw),
        .led          (led),
        .mirrorEnable (mirrorEnable)
    );

endmodule

`default_nettype wire

// ==== verification/boardTop_tb.sv ====
// Self-checking testbench for boardTop, replays the command file and checks reads, LEDs and credits
`timescale 1ns/1ps
`default_nettype none

module boardTop_tb
    import socBusPkg::*;
();

    localparam int    CMD_DEPTH     = 4;
    localparam int    MIRROR_PERIOD = 16;
    localparam int    DRAIN_LIMIT   = 200;
    localparam string INPUT_FILE    = "verification/boardTopInput.txt";

    logic     clk;
    logic     arstN;
    busData_t sw;
    busData_t led;
    logic     cmdValid;
    logic     cmdWrite;
    regAddr_t cmdAddr;
    busData_t cmdData;
    logic     cmdCredit;
    logic     rspValid;
    busData_t rspData;

    // Scoreboard state
    busData_t    expQ[$];
    int          sentCount;
    int          creditPulses;
    int          mismatchCount;
    int          failCount;
    logic [31:0] lfsrState;

    boardTop #(
        .CMD_DEPTH     (CMD_DEPTH),
        .MIRROR_PERIOD (MIRROR_PERIOD)
    ) dut (
        .clk       (clk),
        .arstN     (arstN),
        .sw        (sw),
        .led       (led),
        .cmdValid  (cmdValid),
        .cmdWrite  (cmdWrite),
        .cmdAddr   (cmdAddr),
        .cmdData   (cmdData),
        .cmdCredit (cmdCredit),
        .rspValid  (rspValid),
        .rspData   (rspData)
    );

    always #20 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // Host-side view of the credit pool
    function automatic int creditsLeft();
        return CMD_DEPTH - sentCount + creditPulses;
    endfunction

    // One LFSR step per data bit
    task automatic randomWord(output busData_t value);
        value = '0;
        for (int i = 0; i < BUS_DATA_W; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value[i] = lfsrState[0];
        end
    endtask

    // Registered outputs, read after the edge has settled
    task automatic sampleOutputs();
        busData_t expData;
        if (cmdCredit) begin
            creditPulses++;
        end
        assert (creditsLeft() >= 0 && creditsLeft() <= CMD_DEPTH) else begin
            $display("Credit count left its range, now %0d", creditsLeft());
            failCount++;
        end
        if (rspValid) begin
            if (expQ.size() == 0) begin
                $display("Read response 0x%h arrived with no read outstanding", rspData);
                failCount++;
            end else begin
                expData = expQ.pop_front();
                assert (rspData == expData) else begin
                    $display("Mismatch rspData expected 0x%h actual 0x%h", expData, rspData);
                    mismatchCount++;
                end
            end
        end
    endtask

    // Advance one clock, inputs may change right after
    task automatic tick();
        @(posedge clk);
        #2;
        sampleOutputs();
    endtask

    // Spend a credit, waiting for one if the pool is empty
    task automatic sendCmd(input logic write, input regAddr_t addr, input busData_t data,
                           input busData_t expData);
        int waitCycles;
        waitCycles = 0;
        while (creditsLeft() == 0 && waitCycles < DRAIN_LIMIT) begin
            tick();
            waitCycles++;
        end
        if (creditsLeft() == 0) begin
            $display("Timed out waiting for a command credit");
            failCount++;
        end else begin
            cmdValid = 1'b1;
            cmdWrite = write;
            cmdAddr  = addr;
            cmdData  = data;
            sentCount++;
            if (!write) begin
                expQ.push_back(expData);
            end
            tick();
            cmdValid = 1'b0;
        end
    endtask

    // All credits back and all reads answered
    task automatic drain();
        int waitCycles;
        waitCycles = 0;
        while ((creditPulses != sentCount || expQ.size() != 0) && waitCycles < DRAIN_LIMIT) begin
            tick();
            waitCycles++;
        end
        if (creditPulses != sentCount || expQ.size() != 0) begin
            $display("Timed out draining, %0d credits and %0d reads still outstanding",
                     sentCount - creditPulses, expQ.size());
            failCount++;
        end
    endtask

    // Write then read back the same random word, back to back
    // Register left cleared so later lines of the file can expect zero
    task automatic randomPairs(input regAddr_t addr, input int count);
        busData_t value;
        for (int i = 0; i < count; i++) begin
            randomWord(value);
            sendCmd(1'b1, addr, value, '0);
            sendCmd(1'b0, addr, '0, value);
        end
        sendCmd(1'b1, addr, '0, '0);
    endtask

    // New switch value plus time for the two-flop synchronizer
    task automatic setSwitches(input busData_t value);
        sw = value;
        repeat (4) tick();
    endtask

    // led must hold expLed for the given number of mirror periods
    task automatic checkLed(input busData_t expLed, input int spans);
        int held;
        int cycles;
        drain();
        cycles = spans * MIRROR_PERIOD;
        held = 0;
        while (held < cycles && led == expLed) begin
            tick();
            held++;
        end
        assert (led == expLed) else begin
            $display("Mismatch led expected 0x%h actual 0x%h after %0d cycles", expLed, led, held);
            mismatchCount++;
        end
    endtask

    // Mirror engine should copy sw onto led
    task automatic waitMirror(input int spans);
        int waitCycles;
        int limit;
        limit = spans * MIRROR_PERIOD;
        waitCycles = 0;
        while (led != sw && waitCycles < limit) begin
            tick();
            waitCycles++;
        end
        if (led != sw) begin
            $display("led did not follow sw 0x%h within %0d cycles, led is 0x%h", sw, limit, led);
            failCount++;
        end
    endtask

    task automatic runOp(input logic [7:0] op, input regAddr_t addr, input busData_t data,
                         input logic [31:0] arg);
        case (op)
            "W": sendCmd(1'b1, addr, data, '0);
            "R": sendCmd(1'b0, addr, '0, arg[BUS_DATA_W-1:0]);
            "N": randomPairs(addr, int'(data));
            "S": setSwitches(data);
            "E": checkLed(data, int'(arg));
            "M": waitMirror(int'(arg));
            default: begin
                $display("Unknown op %s in the input file", op);
                failCount++;
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          code;
        logic [63:0] opWord;
        logic [31:0] addrField;
        logic [31:0] dataField;
        logic [31:0] argField;
        logic [8*160-1:0] restLine;

        clk           = 1'b0;
        arstN         = 1'b0;
        sw            = '0;
        cmdValid      = 1'b0;
        cmdWrite      = 1'b0;
        cmdAddr       = '0;
        cmdData       = '0;
        sentCount     = 0;
        creditPulses  = 0;
        mismatchCount = 0;
        failCount     = 0;
        lfsrState     = 32'ha15f;

        repeat (4) tick();
        arstN = 1'b1;
        // Synchronizer needs two edges, plus margin
        repeat (4) tick();

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the input file %s", INPUT_FILE);
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %s", opWord);
                if (code != 1) begin
                    break;
                end
                if (opWord[7:0] == "#") begin
                    code = $fgets(restLine, fd);
                end else begin
                    code = $fscanf(fd, " %h %h %h", addrField, dataField, argField);
                    if (code != 3) begin
                        $display("Malformed input line for op %s", opWord);
                        failCount++;
                        break;
                    end
                    runOp(opWord[7:0], addrField[REG_ADDR_W-1:0],
                          dataField[BUS_DATA_W-1:0], argField);
                end
            end
            $fclose(fd);
        end

        // Every credit must have come home
        drain();
        assert (creditsLeft() == CMD_DEPTH) else begin
            $display("Mismatch creditsLeft expected 0x%h actual 0x%h", CMD_DEPTH, creditsLeft());
            mismatchCount++;
        end
        assert (creditPulses == sentCount) else begin
            $display("Mismatch cmdCredit expected 0x%h actual 0x%h", sentCount, creditPulses);
            mismatchCount++;
        end

        $display("Commands %0d, mismatches %0d, other errors %0d",
                 sentCount, mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/boardTopInput.txt ====
# op addr data arg, fields in hex. W write, R read with arg as expected data
# N data random write/read pairs, S sets sw, E led equals data for arg periods, M led follows sw in arg periods
N 3 2 0
W 3 beef 0
R 3 0 beef
W 3 1234 0
R 3 0 1234
R 3 0 1234
W 3 0 0
R 3 0 0
W 0 a5a5 0
E 0 a5a5 0
R 0 0 a5a5
N 0 3 0
S 0 3c5a 0
R 1 0 3c5a
W 1 ffff 0
R 1 0 3c5a
R 7 0 0
R f 0 0
W 2 1 0
R 2 0 1
S 0 96e1 0
N 3 8 0
M 0 0 4
R 1 0 96e1
R 3 0 0
W 2 0 0
E 0 96e1 1
W 0 0f0f 0
E 0 0f0f 4
R 0 0 0f0f

// ==== boardTop.f ====
hw/socBusPkg.sv
hw/gpioRegs.sv
hw/busArbiter.sv
hw/switchMirror.sv
hw/hostCmdPort.sv
hw/boardTop.sv
verification/boardTop_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = boardTop_tb
FILELIST  = boardTop.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
